/* files.f */
cpu_pkg.sv
alu.sv
alu_engine.sv
wb_arbiter.sv
wb_ram.sv
alu_cluster.sv
alu_cluster_properties.sv
tb_alu_cluster.sv

/* tb_alu_cluster.sv */
`timescale 1ns/10ps

module tb_alu_cluster;

    typedef struct {
        string            name;
        logic             eng;
        cpu_pkg::alu_op_t op;
        cpu_pkg::word_t   a;
        cpu_pkg::word_t   b;
        logic             together;     // runs at once with the next entry.
    } entry_t;

    logic              clk;
    logic              rst_n;
    cpu_pkg::alu_cmd_t cmd0;
    logic              cmd0_valid;
    logic              cmd0_ready;
    logic              done0;
    cpu_pkg::flags_t   flags0;
    cpu_pkg::alu_cmd_t cmd1;
    logic              cmd1_valid;
    logic              cmd1_ready;
    logic              done1;
    cpu_pkg::flags_t   flags1;
    cpu_pkg::wb_req_t  host_req;
    cpu_pkg::wb_rsp_t  host_rsp;

    entry_t tests [$];
    logic   carry_state [2];            // stored carry per engine.
    int     value_errors;
    int     other_errors;
    int     cycles;
    int     cycle_limit;

    alu_cluster #(
        .ram_words (256)
    ) dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd0       (cmd0),
        .cmd0_valid (cmd0_valid),
        .cmd0_ready (cmd0_ready),
        .done0      (done0),
        .flags0     (flags0),
        .cmd1       (cmd1),
        .cmd1_valid (cmd1_valid),
        .cmd1_ready (cmd1_ready),
        .done1      (done1),
        .flags1     (flags1),
        .host_req   (host_req),
        .host_rsp   (host_rsp)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ****************************************
    // compare tasks
    // ****************************************
    task automatic check_word(string name, cpu_pkg::word_t exp, cpu_pkg::word_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_flags(string name, cpu_pkg::flags_t exp, cpu_pkg::flags_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            value_errors++;
        end
    endtask

    // ****************************************
    // reference model
    // ****************************************
    function automatic cpu_pkg::word_t model_alu(cpu_pkg::alu_op_t op, cpu_pkg::word_t a,
                                                 cpu_pkg::word_t b, logic cin,
                                                 output cpu_pkg::flags_t fl);
        logic [32:0]        w;
        logic               ov;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [31:0]        ua;
        logic [31:0]        ub;
        ov = 1'b0;
        w  = '0;
        case (op)
            cpu_pkg::OP_ADD:        w = 33'(a) + 33'(b);
            cpu_pkg::OP_ADDC:       w = 33'(a) + 33'(b) + 33'(cin);
            cpu_pkg::OP_SUB,
            cpu_pkg::OP_COMP:       w = 33'(a) - 33'(b);
            cpu_pkg::OP_SUBC:       w = 33'(a) - 33'(b) - 33'(cin);
            cpu_pkg::OP_AND,
            cpu_pkg::OP_BIT:        w = 33'(a & b);
            cpu_pkg::OP_OR:         w = 33'(a | b);
            cpu_pkg::OP_XOR:        w = 33'(a ^ b);
            cpu_pkg::OP_TEST:       w = 33'(a);
            cpu_pkg::OP_MULU: begin
                ua = a[15:0];
                ub = b[15:0];
                w  = {1'b0, ua * ub};
            end
            cpu_pkg::OP_MULS: begin
                sa = $signed(a[15:0]);
                sb = $signed(b[15:0]);
                w  = {1'b0, sa * sb};
            end
            cpu_pkg::OP_INC:        w = 33'(a) + 33'd1;
            cpu_pkg::OP_DEC:        w = 33'(a) - 33'd1;
            cpu_pkg::OP_NOT:        w = {1'b0, ~a};
            cpu_pkg::OP_NEG:        w = 33'd0 - 33'(a);
            cpu_pkg::OP_SWAP:       w = {1'b0, a[15:0], a[31:16]};
            cpu_pkg::OP_LOGIC_LEFT,
            cpu_pkg::OP_ARITH_LEFT: w = {a, 1'b0};
            cpu_pkg::OP_LOGIC_RIGHT: begin
                w[32]   = a[0];                 // shifted-out bit lands in carry.
                w[31:0] = a >> 1;
            end
            cpu_pkg::OP_ARITH_RIGHT: begin
                w[32]   = a[0];
                w[31:0] = $signed(a) >>> 1;
            end
            cpu_pkg::OP_SIGN_EXT_B: begin
                sa = $signed(a[7:0]);
                w  = {1'b0, sa};
            end
            cpu_pkg::OP_SIGN_EXT_W: begin
                sa = $signed(a[15:0]);
                w  = {1'b0, sa};
            end
            default:                w = '0;
        endcase
        if (op == cpu_pkg::OP_ADD || op == cpu_pkg::OP_ADDC)
            ov = (a[31] == b[31]) && (w[31] != a[31]);
        else if (op == cpu_pkg::OP_SUB || op == cpu_pkg::OP_SUBC)
            ov = (a[31] != b[31]) && (w[31] != a[31]);
        else if (op == cpu_pkg::OP_ARITH_LEFT)
            ov = a[31] ^ a[30];
        fl = '{carry: w[32], zero: (w[31:0] == 32'h0), neg: w[31], over: ov};
        return w[31:0];
    endfunction

    function automatic logic flag_only(cpu_pkg::alu_op_t op);
        return op == cpu_pkg::OP_COMP || op == cpu_pkg::OP_BIT || op == cpu_pkg::OP_TEST;
    endfunction

    function automatic cpu_pkg::addr_t base_of(int idx);
        return cpu_pkg::addr_t'(3 * idx);
    endfunction

    function automatic cpu_pkg::word_t sentinel(int idx);
        return 32'hc0de_0000 + idx;
    endfunction

    // ****************************************
    // bus and command drivers
    // ****************************************
    task automatic host_access(logic we, cpu_pkg::addr_t adr, cpu_pkg::word_t dat,
                               output cpu_pkg::word_t rdat);
        int waited;
        waited = 0;
        @(negedge clk);
        host_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        do begin
            @(negedge clk);
            waited++;
        end while (!host_rsp.ack && waited < 100);
        if (!host_rsp.ack) begin
            $display("host access to address %h was never acknowledged", adr);
            other_errors++;
        end
        rdat     = host_rsp.dat;
        host_req = '0;
    endtask

    task automatic host_write(cpu_pkg::addr_t adr, cpu_pkg::word_t dat);
        cpu_pkg::word_t unused;
        host_access(1'b1, adr, dat, unused);
    endtask

    task automatic host_read(cpu_pkg::addr_t adr, output cpu_pkg::word_t dat);
        host_access(1'b0, adr, 32'h0, dat);
    endtask

    task automatic host_scratch(int idx);
        cpu_pkg::word_t v;
        cpu_pkg::word_t rd;
        v = 32'h600d_0000 ^ (idx * 32'h0001_0101);
        host_write(8'hf0, v);
        host_read(8'hf0, rd);
        check_word("host_scratch", v, rd);
    endtask

    task automatic run_command(entry_t e, cpu_pkg::addr_t base, output cpu_pkg::flags_t fl);
        cpu_pkg::alu_cmd_t c;
        int                waited;
        logic              got;
        c      = '{op: e.op, src_a: base, src_b: base + 8'd1, dst: base + 8'd2};
        waited = 0;
        got    = 1'b0;
        @(negedge clk);
        while (!(e.eng ? cmd1_ready : cmd0_ready))
            @(negedge clk);
        if (e.eng) begin
            cmd1       = c;
            cmd1_valid = 1'b1;
        end else begin
            cmd0       = c;
            cmd0_valid = 1'b1;
        end
        @(negedge clk);
        if (e.eng)
            cmd1_valid = 1'b0;
        else
            cmd0_valid = 1'b0;
        while (!got && waited < 100) begin
            got = e.eng ? done1 : done0;
            if (!got) begin
                @(negedge clk);
                waited++;
            end
        end
        fl = e.eng ? flags1 : flags0;
        if (!got) begin
            $display("engine %0d never signalled done for %s", e.eng, e.name);
            other_errors++;
        end
    endtask

    // one entry alone, or two entries on both engines with host traffic alongside.
    task automatic run_group(int first, int count);
        cpu_pkg::flags_t exp_fl [2];
        cpu_pkg::flags_t got_fl [2];
        cpu_pkg::word_t  exp_ram [2];
        cpu_pkg::word_t  res;
        cpu_pkg::word_t  rd;
        entry_t          e;
        for (int j = 0; j < count; j++) begin
            e = tests[first + j];
            host_write(base_of(first + j), e.a);
            host_write(base_of(first + j) + 8'd1, e.b);
            host_write(base_of(first + j) + 8'd2, sentinel(first + j));
            res = model_alu(e.op, e.a, e.b, carry_state[e.eng], exp_fl[j]);
            carry_state[e.eng] = exp_fl[j].carry;
            exp_ram[j] = flag_only(e.op) ? sentinel(first + j) : res;
        end
        if (count == 1) begin
            run_command(tests[first], base_of(first), got_fl[0]);
        end else begin
            fork
                run_command(tests[first], base_of(first), got_fl[0]);
                run_command(tests[first + 1], base_of(first + 1), got_fl[1]);
                host_scratch(first);
            join
        end
        for (int j = 0; j < count; j++) begin
            check_flags({tests[first + j].name, " flags"}, exp_fl[j], got_fl[j]);
            host_read(base_of(first + j) + 8'd2, rd);
            check_word({tests[first + j].name, " dst"}, exp_ram[j], rd);
        end
    endtask

    task automatic add_entry(string name, logic eng, cpu_pkg::alu_op_t op,
                             cpu_pkg::word_t a, cpu_pkg::word_t b, logic together);
        entry_t e;
        e = '{name, eng, op, a, b, together};
        tests.push_back(e);
    endtask

    // ****************************************
    // stimulus table
    // ****************************************
    task automatic build_table();
        add_entry("add_basic", 0, cpu_pkg::OP_ADD, 32'd5, 32'd7, 0);
        add_entry("add_ovf", 0, cpu_pkg::OP_ADD, 32'h7fff_ffff, 32'd1, 0);
        add_entry("add_carry", 0, cpu_pkg::OP_ADD, 32'hffff_ffff, 32'd1, 0);
        add_entry("addc_chain", 0, cpu_pkg::OP_ADDC, 32'd10, 32'd20, 0);
        add_entry("sub_borrow", 1, cpu_pkg::OP_SUB, 32'd3, 32'd5, 0);
        add_entry("subc_chain", 1, cpu_pkg::OP_SUBC, 32'd100, 32'd1, 0);
        add_entry("sub_ovf", 1, cpu_pkg::OP_SUB, 32'h8000_0000, 32'd1, 0);
        add_entry("mulu", 0, cpu_pkg::OP_MULU, 32'h0001_ffff, 32'h0000_ffff, 0);
        add_entry("muls", 1, cpu_pkg::OP_MULS, 32'h0000_ffff, 32'd2, 0);
        add_entry("xor", 0, cpu_pkg::OP_XOR, 32'hf0f0_1234, 32'h0ff0_1234, 0);
        add_entry("comp_eq", 0, cpu_pkg::OP_COMP, 32'd42, 32'd42, 0);
        add_entry("bit_clear", 1, cpu_pkg::OP_BIT, 32'h0000_00f0, 32'h0000_000f, 0);
        add_entry("test_neg", 0, cpu_pkg::OP_TEST, 32'h8000_0000, 32'd0, 0);
        add_entry("inc_wrap", 1, cpu_pkg::OP_INC, 32'hffff_ffff, 32'd0, 0);
        add_entry("dec_zero", 0, cpu_pkg::OP_DEC, 32'd0, 32'd0, 0);
        add_entry("not", 1, cpu_pkg::OP_NOT, 32'h1234_5678, 32'd0, 0);
        add_entry("neg", 0, cpu_pkg::OP_NEG, 32'd1, 32'd0, 0);
        add_entry("swap", 1, cpu_pkg::OP_SWAP, 32'h1234_5678, 32'd0, 0);
        add_entry("lsl", 0, cpu_pkg::OP_LOGIC_LEFT, 32'h8000_0001, 32'd0, 0);
        add_entry("lsr_carry", 1, cpu_pkg::OP_LOGIC_RIGHT, 32'd3, 32'd0, 0);
        add_entry("asl_ovf", 0, cpu_pkg::OP_ARITH_LEFT, 32'h4000_0000, 32'd0, 0);
        add_entry("asr", 1, cpu_pkg::OP_ARITH_RIGHT, 32'h8000_0001, 32'd0, 0);
        add_entry("sext_b", 0, cpu_pkg::OP_SIGN_EXT_B, 32'h0000_1280, 32'd0, 0);
        add_entry("sext_w", 1, cpu_pkg::OP_SIGN_EXT_W, 32'h0001_8000, 32'd0, 0);
        add_entry("rand_add", 0, cpu_pkg::OP_ADD, $urandom(), $urandom(), 1);
        add_entry("rand_sub", 1, cpu_pkg::OP_SUB, $urandom(), $urandom(), 0);
        add_entry("rand_muls", 0, cpu_pkg::OP_MULS, $urandom(), $urandom(), 1);
        add_entry("rand_addc", 1, cpu_pkg::OP_ADDC, $urandom(), $urandom(), 0);
        add_entry("rand_xor", 1, cpu_pkg::OP_XOR, $urandom(), $urandom(), 1);
        add_entry("rand_comp", 0, cpu_pkg::OP_COMP, $urandom(), $urandom(), 0);
    endtask

    initial begin
        cpu_pkg::word_t rd;
        int             i;
        void'($urandom(32'h9e321f7c));
        clk          = 1'b0;
        rst_n        = 1'b0;
        cmd0         = '0;
        cmd0_valid   = 1'b0;
        cmd1         = '0;
        cmd1_valid   = 1'b0;
        host_req     = '0;
        value_errors = 0;
        other_errors = 0;
        cycles       = 0;
        cycle_limit  = 100;
        carry_state  = '{1'b0, 1'b0};
        build_table();
        cycle_limit = 40 * tests.size() + 100;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_bit("reset cmd0_ready", 1'b1, cmd0_ready);
        check_bit("reset cmd1_ready", 1'b1, cmd1_ready);
        check_bit("reset done0", 1'b0, done0);
        check_bit("reset done1", 1'b0, done1);
        check_bit("reset host ack", 1'b0, host_rsp.ack);
        host_write(8'hff, 32'h5a5a_c3c3);
        host_read(8'hff, rd);
        check_word("host_loopback", 32'h5a5a_c3c3, rd);
        i = 0;
        while (i < tests.size()) begin
            if (tests[i].together && i + 1 < tests.size()) begin
                run_group(i, 2);
                i += 2;
            end else begin
                run_group(i, 1);
                i += 1;
            end
        end
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* alu_cluster_properties.sv */
`timescale 1ns/10ps

module alu_cluster_properties #(
    parameter int n = 1
) (
    input logic             clk,
    input logic             rst_n,
    input cpu_pkg::wb_req_t req,
    input logic             ack,
    input logic [n-1:0]     grant,      // bus owner, one bit per master.
    input logic             done
);

    // ****************************************
    // wishbone classic
    // ****************************************
    stb_held: assert property (@(posedge clk) disable iff (!rst_n)
        (req.cyc && req.stb && !ack) |=> (ack || (req.stb && $stable(req.adr))))
        else $error("stb dropped or address changed before ack");

    if (n > 1) begin : g_arbiter
        one_grant: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(grant))
            else $error("more than one master granted");
    end else begin : g_engine
        // a master with cyc low does not own the bus.
        ack_to_owner: assert property (@(posedge clk) disable iff (!rst_n)
            !(ack && !grant[0]))
            else $error("ack seen by a master that does not own the bus");

        // ****************************************
        // command handshake
        // ****************************************
        done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
            done |=> !done)
            else $error("done held longer than one cycle");
    end

endmodule

bind alu_engine alu_cluster_properties #(.n(1)) u_engine_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (wb_req),
    .ack     (wb_rsp.ack),
    .grant   (wb_req.cyc),
    .done    (done)
);

bind wb_arbiter alu_cluster_properties #(.n(3)) u_arbiter_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (s_req),
    .ack     (s_rsp.ack),
    .grant   (grant),
    .done    (1'b0)
);

/* alu_cluster.sv */
`timescale 1ns/10ps

module alu_cluster #(
    parameter int ram_words = 256
) (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::alu_cmd_t cmd0,
    input  logic              cmd0_valid,
    output logic              cmd0_ready,
    output logic              done0,
    output cpu_pkg::flags_t   flags0,
    input  cpu_pkg::alu_cmd_t cmd1,
    input  logic              cmd1_valid,
    output logic              cmd1_ready,
    output logic              done1,
    output cpu_pkg::flags_t   flags1,
    input  cpu_pkg::wb_req_t  host_req,
    output cpu_pkg::wb_rsp_t  host_rsp
);

    localparam int num_masters = 3;     // engine 0, engine 1, host.

    cpu_pkg::wb_req_t m_req [num_masters];
    cpu_pkg::wb_rsp_t m_rsp [num_masters];
    cpu_pkg::wb_req_t s_req;
    cpu_pkg::wb_rsp_t s_rsp;

    assign m_req[2] = host_req;
    assign host_rsp = m_rsp[2];

    alu_engine u_engine0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd0),
        .cmd_valid (cmd0_valid),
        .cmd_ready (cmd0_ready),
        .done      (done0),
        .flags     (flags0),
        .wb_req    (m_req[0]),
        .wb_rsp    (m_rsp[0])
    );

    alu_engine u_engine1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd1),
        .cmd_valid (cmd1_valid),
        .cmd_ready (cmd1_ready),
        .done      (done1),
        .flags     (flags1),
        .wb_req    (m_req[1]),
        .wb_rsp    (m_rsp[1])
    );

    wb_arbiter #(
        .num_masters (num_masters)
    ) u_arbiter (
        .clk   (clk),
        .rst_n (rst_n),
        .m_req (m_req),
        .m_rsp (m_rsp),
        .s_req (s_req),
        .s_rsp (s_rsp)
    );

    wb_ram #(
        .ram_words (ram_words)
    ) u_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (s_req),
        .rsp   (s_rsp)
    );

endmodule

/* wb_ram.sv */
`timescale 1ns/10ps

module wb_ram #(
    parameter int ram_words = 256
) (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::wb_req_t req,
    output cpu_pkg::wb_rsp_t rsp
);

    cpu_pkg::word_t mem [ram_words];
    cpu_pkg::word_t rd_q;
    logic           ack_q;
    logic           hit;

    // a held stb during the ack cycle is not a new access.
    assign hit = req.cyc && req.stb && !ack_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ack_q <= 1'b0;
        else
            ack_q <= hit;
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            if (req.we)
                mem[req.adr] <= req.dat;
            rd_q <= mem[req.adr];
        end
    end

    assign rsp = '{
        ack: ack_q,
        dat: rd_q
    };

endmodule

/* wb_arbiter.sv */
`timescale 1ns/10ps

module wb_arbiter #(
    parameter int num_masters = 3
) (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::wb_req_t m_req [num_masters],
    output cpu_pkg::wb_rsp_t m_rsp [num_masters],
    output cpu_pkg::wb_req_t s_req,
    input  cpu_pkg::wb_rsp_t s_rsp
);

    localparam int idx_w = (num_masters > 1) ? $clog2(num_masters) : 1;

    logic [num_masters-1:0] grant;          // registered owner, one-hot.
    logic [idx_w-1:0]       last_owner;
    logic [num_masters-1:0] next_grant;
    logic [idx_w-1:0]       next_owner;
    logic [idx_w-1:0]       cand;
    logic                   owner_cyc;

    // round-robin search starting after the last owner.
    always_comb begin
        next_grant = '0;
        next_owner = last_owner;
        cand       = last_owner;
        for (int k = 0; k < num_masters; k++) begin
            cand = (cand == idx_w'(num_masters - 1)) ? '0 : cand + 1'b1;
            if (next_grant == '0 && m_req[cand].cyc) begin
                next_grant[cand] = 1'b1;
                next_owner       = cand;
            end
        end
    end

    always_comb begin
        s_req     = '0;
        owner_cyc = 1'b0;
        for (int i = 0; i < num_masters; i++) begin
            if (grant[i]) begin
                s_req     = m_req[i];
                owner_cyc = m_req[i].cyc;
            end
        end
        for (int i = 0; i < num_masters; i++) begin
            m_rsp[i].ack = s_rsp.ack && grant[i];   // only the owner sees ack.
            m_rsp[i].dat = s_rsp.dat;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant      <= '0;
            last_owner <= idx_w'(num_masters - 1);  // engine 0 wins first.
        end else if (grant != '0) begin
            if (!owner_cyc)
                grant <= '0;
        end else if (next_grant != '0) begin
            grant      <= next_grant;
            last_owner <= next_owner;
        end
    end

endmodule

/* alu_engine.sv */
`timescale 1ns/10ps

module alu_engine (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::alu_cmd_t cmd,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    output logic              done,
    output cpu_pkg::flags_t   flags,
    output cpu_pkg::wb_req_t  wb_req,
    input  cpu_pkg::wb_rsp_t  wb_rsp
);

    // uncontended, done comes 12 cycles after acceptance with a write-back
    // and 9 without. cyc drops for a cycle between accesses.
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ_A,
        ST_READ_B,
        ST_EXECUTE,
        ST_WRITE,
        ST_REPORT
    } state_t;

    state_t            state;
    cpu_pkg::alu_cmd_t cmd_q;
    cpu_pkg::word_t    opa;
    cpu_pkg::word_t    opb;
    cpu_pkg::wb_req_t  req_q;
    cpu_pkg::flags_t   flags_q;
    logic              carry_q;      // carry of the previous operation.
    cpu_pkg::word_t    alu_result;
    cpu_pkg::flags_t   alu_flags;
    logic              bus_ack;

    assign bus_ack = req_q.cyc && wb_rsp.ack;

    alu u_alu (
        .op       (cmd_q.op),
        .reg2     (opa),
        .reg3     (opb),
        .carry_in (carry_q),
        .result   (alu_result),
        .flags    (alu_flags)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            req_q   <= '0;
            flags_q <= '0;
            carry_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_valid) begin
                        req_q.cyc <= 1'b1;
                        req_q.stb <= 1'b1;
                        req_q.we  <= 1'b0;
                        req_q.adr <= cmd.src_a;
                        state     <= ST_READ_A;
                    end
                end
                ST_READ_A: begin
                    if (bus_ack) begin
                        req_q.cyc <= 1'b0;
                        req_q.stb <= 1'b0;
                        state     <= ST_READ_B;
                    end
                end
                ST_READ_B: begin
                    if (!req_q.cyc) begin
                        req_q.cyc <= 1'b1;          // new cycle after the idle gap.
                        req_q.stb <= 1'b1;
                        req_q.adr <= cmd_q.src_b;
                    end else if (bus_ack) begin
                        req_q.cyc <= 1'b0;
                        req_q.stb <= 1'b0;
                        state     <= ST_EXECUTE;
                    end
                end
                ST_EXECUTE: begin
                    flags_q <= alu_flags;
                    if (cpu_pkg::writes_result(cmd_q.op)) begin
                        req_q.cyc <= 1'b1;
                        req_q.stb <= 1'b1;
                        req_q.we  <= 1'b1;
                        req_q.adr <= cmd_q.dst;
                        req_q.dat <= alu_result;
                        state     <= ST_WRITE;
                    end else begin
                        state <= ST_REPORT;
                    end
                end
                ST_WRITE: begin
                    if (bus_ack) begin
                        req_q.cyc <= 1'b0;
                        req_q.stb <= 1'b0;
                        req_q.we  <= 1'b0;
                        state     <= ST_REPORT;
                    end
                end
                ST_REPORT: begin
                    carry_q <= flags_q.carry;
                    state   <= ST_IDLE;
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cmd_valid)
            cmd_q <= cmd;
        if (state == ST_READ_A && bus_ack)
            opa <= wb_rsp.dat;
        if (state == ST_READ_B && bus_ack)
            opb <= wb_rsp.dat;
    end

    assign cmd_ready = (state == ST_IDLE);
    assign done      = (state == ST_REPORT);
    assign flags     = flags_q;
    assign wb_req    = req_q;

endmodule

/* alu.sv */
`timescale 1ns/10ps

module alu (
    input  cpu_pkg::alu_op_t op,
    input  cpu_pkg::word_t   reg2,
    input  cpu_pkg::word_t   reg3,
    input  logic             carry_in,
    output cpu_pkg::word_t   result,
    output cpu_pkg::flags_t  flags
);

    logic [32:0]    a_ext;
    logic [32:0]    b_ext;
    logic [32:0]    wide;           // bit 32 is the carry.
    cpu_pkg::word_t short_prod;
    logic           over;

    assign a_ext = {1'b0, reg2};
    assign b_ext = {1'b0, reg3};

    // ****************************************
    // 33-bit result per opcode
    // ****************************************
    always_comb begin
        short_prod = '0;
        case (op)
            cpu_pkg::OP_ADD:
                wide = a_ext + b_ext;
            cpu_pkg::OP_ADDC:
                wide = a_ext + b_ext + {32'h0, carry_in};
            cpu_pkg::OP_SUB:
                wide = a_ext - b_ext;
            cpu_pkg::OP_SUBC:
                wide = a_ext - b_ext - {32'h0, carry_in};
            cpu_pkg::OP_AND:
                wide = a_ext & b_ext;
            cpu_pkg::OP_OR:
                wide = a_ext | b_ext;
            cpu_pkg::OP_XOR:
                wide = a_ext ^ b_ext;
            cpu_pkg::OP_COMP:
                wide = a_ext - b_ext;
            cpu_pkg::OP_BIT:
                wide = a_ext & b_ext;
            cpu_pkg::OP_TEST:
                wide = a_ext;
            cpu_pkg::OP_MULU: begin
                short_prod = reg2[15:0] * reg3[15:0];
                wide       = {1'b0, short_prod};
            end
            cpu_pkg::OP_MULS: begin
                short_prod = $signed(reg2[15:0]) * $signed(reg3[15:0]);
                wide       = {1'b0, short_prod};
            end
            cpu_pkg::OP_INC:
                wide = a_ext + 33'd1;
            cpu_pkg::OP_DEC:
                wide = a_ext - 33'd1;
            cpu_pkg::OP_NOT:
                wide = ~{1'b1, reg2};
            cpu_pkg::OP_NEG:
                wide = ~a_ext + 33'd1;
            cpu_pkg::OP_SWAP:
                wide = {1'b0, reg2[15:0], reg2[31:16]};
            cpu_pkg::OP_LOGIC_LEFT:
                wide = a_ext << 1;
            cpu_pkg::OP_LOGIC_RIGHT:
                wide = {reg2[0], 1'b0, reg2[31:1]};         // bit 0 rotates into carry.
            cpu_pkg::OP_ARITH_LEFT:
                wide = {reg2, 1'b0};
            cpu_pkg::OP_ARITH_RIGHT:
                wide = {reg2[0], reg2[31], reg2[31:1]};
            cpu_pkg::OP_SIGN_EXT_B:
                wide = {1'b0, {24{reg2[7]}}, reg2[7:0]};
            cpu_pkg::OP_SIGN_EXT_W:
                wide = {1'b0, {16{reg2[15]}}, reg2[15:0]};
            default:
                wide = '0;
        endcase
    end

    // ****************************************
    // signed overflow
    // ****************************************
    always_comb begin
        case (op)
            cpu_pkg::OP_ADD,
            cpu_pkg::OP_ADDC:
                over = (reg3[31] != wide[31]) && (reg2[31] != wide[31]);
            // operand b sign is inverted for a subtract.
            cpu_pkg::OP_SUB,
            cpu_pkg::OP_SUBC:
                over = (reg3[31] == wide[31]) && (reg2[31] != wide[31]);
            cpu_pkg::OP_ARITH_LEFT:
                over = reg2[31] != wide[31];                // sign bit changed.
            default:
                over = 1'b0;
        endcase
    end

    assign result = cpu_pkg::writes_result(op) ? wide[31:0] : reg2;

    assign flags = '{
        carry: wide[32],
        zero:  (wide[31:0] == 32'h0),
        neg:   wide[31],
        over:  over
    };

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] word_t;    // data word.
    typedef logic [7:0]  addr_t;    // ram word address.

    // ****************************************
    // alu opcodes
    // ****************************************
    typedef enum logic [4:0] {
        OP_ADD,
        OP_ADDC,
        OP_SUB,
        OP_SUBC,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_COMP,                    // flags only.
        OP_BIT,                     // flags only.
        OP_TEST,                    // flags only.
        OP_MULU,
        OP_MULS,
        OP_INC,
        OP_DEC,
        OP_NOT,
        OP_NEG,
        OP_SWAP,
        OP_LOGIC_LEFT,
        OP_LOGIC_RIGHT,
        OP_ARITH_LEFT,
        OP_ARITH_RIGHT,
        OP_SIGN_EXT_B,
        OP_SIGN_EXT_W
    } alu_op_t;

    typedef struct packed {
        logic carry;
        logic zero;
        logic neg;
        logic over;
    } flags_t;

    typedef struct packed {
        alu_op_t op;
        addr_t   src_a;
        addr_t   src_b;
        addr_t   dst;
    } alu_cmd_t;

    // ****************************************
    // wishbone classic
    // ****************************************
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        word_t dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    function automatic logic writes_result(alu_op_t op);
        return !(op inside {OP_COMP, OP_BIT, OP_TEST});
    endfunction

endpackage
